//--- bp_cfg.svh
// Sizes are fixed at compile time; BP_BTB_ENTRIES must be a power of two and BP_XLEN stays 32
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Address width of the pipeline
`define BP_XLEN 32

// Target buffer depth, direct mapped
`define BP_BTB_ENTRIES 32

// Index bits into the target buffer
`define BP_BTB_IDX_BITS $clog2(`BP_BTB_ENTRIES)

// Global history length, also the pattern table index width
`define BP_GHR_BITS 5

// Pattern table depth follows from the history length
`define BP_PHT_ENTRIES (1 << `BP_GHR_BITS)

`endif

//--- bp_pkg.sv
// Shared types only; opcode values cover just the major RISC-V control-flow opcodes
`include "bp_cfg.svh"

package bp_pkg;

    // Major opcodes seen by the predictor
    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // What the buffer remembers about an instruction
    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_COND = 2'd1,
        KIND_JUMP = 2'd2
    } br_kind_e;

    // Prediction carried down the pipeline with the instruction
    typedef struct packed {
        logic                    taken;
        logic [`BP_XLEN-1:0]     target;
        logic                    btb_hit;
        logic [`BP_GHR_BITS-1:0] pht_index;
    } bp_pred_t;

    // Report from execute for one resolved instruction
    typedef struct packed {
        logic [`BP_XLEN-1:0] pc;
        opcode_e             opcode;
        logic                actual_taken;
        logic [`BP_XLEN-1:0] actual_target;
        bp_pred_t            pred;
    } bp_resolve_t;

    // Target buffer replacement command
    typedef struct packed {
        logic [`BP_XLEN-1:0] pc;
        logic [`BP_XLEN-1:0] target;
        br_kind_e            kind;
    } btb_wr_t;

    // Counter step command
    typedef struct packed {
        logic [`BP_GHR_BITS-1:0] index;
        logic                    taken;
    } pht_wr_t;

endpackage

//--- bp_op_decode.sv
// Combinational; any encoding other than BRANCH, JAL or JALR, X included, yields KIND_NONE
`timescale 1ns/100ps

module bp_op_decode (
    input  bp_pkg::opcode_e  opcode_i,
    output bp_pkg::br_kind_e kind_o
);

    import bp_pkg::*;

    logic [6:0] op_raw;

    // Compare on raw bits so that encodings outside the enum fall to default
    assign op_raw = opcode_i;

    always_comb begin
        case (op_raw)
            OP_BRANCH: begin
                kind_o = KIND_COND;
            end
            OP_JAL: begin
                kind_o = KIND_JUMP;
            end
            OP_JALR: begin
                // Indirect jumps share the jump kind, target comes from the buffer
                kind_o = KIND_JUMP;
            end
            default: begin
                kind_o = KIND_NONE;
            end
        endcase
    end

endmodule

//--- bp_btb.sv
// Direct mapped with full pc tags; a write always replaces the entry at its index
`timescale 1ns/100ps
`include "bp_cfg.svh"

module bp_btb (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [`BP_XLEN-1:0] lookup_pc_i,
    output logic                hit_o,
    output bp_pkg::br_kind_e    kind_o,
    output logic [`BP_XLEN-1:0] target_o,
    input  logic                wr_valid_i,
    input  bp_pkg::btb_wr_t     wr_i
);

    import bp_pkg::*;

    localparam int IDX_BITS = `BP_BTB_IDX_BITS;
    localparam int ENTRIES  = `BP_BTB_ENTRIES;

    // Entry storage
    logic [ENTRIES-1:0]  valid_q;
    logic [`BP_XLEN-1:0] tag_q    [ENTRIES];
    logic [`BP_XLEN-1:0] target_q [ENTRIES];
    br_kind_e            kind_q   [ENTRIES];

    logic [IDX_BITS-1:0] lookup_idx;
    logic [IDX_BITS-1:0] wr_idx;

    // Word aligned pcs, so the two low bits are skipped
    assign lookup_idx = lookup_pc_i[IDX_BITS+1:2];
    assign wr_idx     = wr_i.pc[IDX_BITS+1:2];

    // Lookup
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_pc_i);
    assign kind_o   = kind_q[lookup_idx];
    assign target_o = target_q[lookup_idx];

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry contents, old entry at the same index is simply overwritten
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            tag_q[wr_idx]    <= wr_i.pc;
            target_q[wr_idx] <= wr_i.target;
            kind_q[wr_idx]   <= wr_i.kind;
        end
    end

endmodule

//--- bp_gshare.sv
// History is non-speculative and shifts only on resolved conditional branches; reset is its only clear
`timescale 1ns/100ps
`include "bp_cfg.svh"

module bp_gshare (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`BP_XLEN-1:0]     lookup_pc_i,
    output logic                    taken_o,
    output logic [`BP_GHR_BITS-1:0] index_o,
    input  logic                    wr_valid_i,
    input  bp_pkg::pht_wr_t         wr_i
);

    localparam int GHR_BITS    = `BP_GHR_BITS;
    localparam int PHT_ENTRIES = `BP_PHT_ENTRIES;

    logic [GHR_BITS-1:0] ghr_q;
    logic [1:0]          pht_q [PHT_ENTRIES];

    logic [1:0] cnt_cur;
    logic [1:0] cnt_next;

    // Gshare index, pc bits folded with history
    assign index_o = lookup_pc_i[GHR_BITS+1:2] ^ ghr_q;
    assign taken_o = pht_q[index_o][1];

    // Saturating step toward the resolved outcome
    assign cnt_cur = pht_q[wr_i.index];

    always_comb begin
        cnt_next = cnt_cur;
        if (wr_i.taken) begin
            if (cnt_cur != 2'b11) begin
                cnt_next = cnt_cur + 2'd1;
            end
        end else begin
            if (cnt_cur != 2'b00) begin
                cnt_next = cnt_cur - 2'd1;
            end
        end
    end

    // Counters start weakly not taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (wr_valid_i) begin
            pht_q[wr_i.index] <= cnt_next;
        end
    end

    // Newest outcome enters at the MSB
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (wr_valid_i) begin
            ghr_q <= {wr_i.taken, ghr_q[GHR_BITS-1:1]};
        end
    end

endmodule

//--- bp_resolve.sv
// Accepts one resolution per cycle without back-pressure; redirect is valid one cycle after the strobe
`timescale 1ns/100ps
`include "bp_cfg.svh"

module bp_resolve (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                resolve_valid_i,
    input  bp_pkg::bp_resolve_t resolve_i,
    input  bp_pkg::br_kind_e    kind_i,
    output logic                btb_wr_valid_o,
    output bp_pkg::btb_wr_t     btb_wr_o,
    output logic                pht_wr_valid_o,
    output bp_pkg::pht_wr_t     pht_wr_o,
    output logic                redirect_o,
    output logic [`BP_XLEN-1:0] redirect_pc_o
);

    import bp_pkg::*;

    logic                is_cf;
    logic                mispredict;
    logic                target_wrong;
    logic [`BP_XLEN-1:0] correct_pc;

    assign is_cf = (kind_i != KIND_NONE);

    // Buffer learns any control-flow instruction it did not know at fetch
    assign btb_wr_valid_o  = resolve_valid_i && is_cf && !resolve_i.pred.btb_hit;
    assign btb_wr_o.pc     = resolve_i.pc;
    assign btb_wr_o.target = resolve_i.actual_target;
    assign btb_wr_o.kind   = kind_i;

    // Counters and history only see conditional branches
    assign pht_wr_valid_o = resolve_valid_i && (kind_i == KIND_COND);
    assign pht_wr_o.index = resolve_i.pred.pht_index;
    assign pht_wr_o.taken = resolve_i.actual_taken;

    // Target matters only when both sides say taken
    assign target_wrong = resolve_i.pred.taken && resolve_i.actual_taken &&
                          (resolve_i.pred.target != resolve_i.actual_target);

    always_comb begin
        if (is_cf) begin
            mispredict = (resolve_i.pred.taken != resolve_i.actual_taken) || target_wrong;
        end else begin
            // Non-branch fetched as taken must be undone
            mispredict = resolve_i.pred.taken;
        end
    end

    assign correct_pc = resolve_i.actual_taken ? resolve_i.actual_target
                                               : resolve_i.pc + `BP_XLEN'(4);

    // Redirect strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_o <= 1'b0;
        end else begin
            redirect_o <= resolve_valid_i && mispredict;
        end
    end

    // Corrected fetch address
    always_ff @(posedge clk) begin
        if (resolve_valid_i) begin
            redirect_pc_o <= correct_pc;
        end
    end

endmodule

//--- bp_unit.sv
// Lookup is same-cycle and side-effect free; table updates become visible the cycle after a strobe
`timescale 1ns/100ps
`include "bp_cfg.svh"

module bp_unit (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [`BP_XLEN-1:0] fetch_pc_i,
    output bp_pkg::bp_pred_t    pred_o,
    input  logic                resolve_valid_i,
    input  bp_pkg::bp_resolve_t resolve_i,
    output logic                redirect_o,
    output logic [`BP_XLEN-1:0] redirect_pc_o
);

    import bp_pkg::*;

    br_kind_e                res_kind;
    logic                    btb_hit;
    br_kind_e                btb_kind;
    logic [`BP_XLEN-1:0]     btb_target;
    logic                    pht_taken;
    logic [`BP_GHR_BITS-1:0] pht_index;
    logic                    btb_wr_valid;
    btb_wr_t                 btb_wr;
    logic                    pht_wr_valid;
    pht_wr_t                 pht_wr;

    bp_op_decode i_decode (
        .opcode_i (resolve_i.opcode),
        .kind_o   (res_kind)
    );

    bp_btb i_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .lookup_pc_i (fetch_pc_i),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target),
        .wr_valid_i  (btb_wr_valid),
        .wr_i        (btb_wr)
    );

    bp_gshare i_gshare (
        .clk         (clk),
        .reset_i     (reset_i),
        .lookup_pc_i (fetch_pc_i),
        .taken_o     (pht_taken),
        .index_o     (pht_index),
        .wr_valid_i  (pht_wr_valid),
        .wr_i        (pht_wr)
    );

    bp_resolve i_resolve (
        .clk             (clk),
        .reset_i         (reset_i),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .kind_i          (res_kind),
        .btb_wr_valid_o  (btb_wr_valid),
        .btb_wr_o        (btb_wr),
        .pht_wr_valid_o  (pht_wr_valid),
        .pht_wr_o        (pht_wr),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    // Prediction assembly
    always_comb begin
        pred_o.btb_hit   = btb_hit;
        pred_o.pht_index = pht_index;
        if (btb_hit) begin
            pred_o.target = btb_target;
            case (btb_kind)
                KIND_JUMP: pred_o.taken = 1'b1;
                KIND_COND: pred_o.taken = pht_taken;
                default:   pred_o.taken = 1'b0;
            endcase
        end else begin
            // Fall through to the next sequential word
            pred_o.taken  = 1'b0;
            pred_o.target = fetch_pc_i + `BP_XLEN'(4);
        end
    end

endmodule

//--- bp_unit_sva.sv
// Checks only the bp_unit ports on rising clock edges; fail_count holds the number of failed assertions
`timescale 1ns/100ps
`include "bp_cfg.svh"

module bp_unit_sva (
    input logic                clk,
    input logic                reset_i,
    input logic [`BP_XLEN-1:0] fetch_pc_i,
    input bp_pkg::bp_pred_t    pred_o,
    input logic                resolve_valid_i,
    input logic                redirect_o
);

    int fail_count = 0;

    // Redirect is cleared by reset
    a_reset_redirect: assert property (@(posedge clk) reset_i |=> !redirect_o)
        else begin
            fail_count++;
            $error("redirect_o is high in the cycle after reset");
        end

    // A redirect only appears one cycle after a resolve strobe
    a_redirect_follows_strobe: assert property (
        @(posedge clk) disable iff (reset_i)
        redirect_o |-> $past(resolve_valid_i))
        else begin
            fail_count++;
            $error("redirect_o is high without a resolve strobe one cycle before");
        end

    // A miss falls through to the next word
    a_miss_fall_through: assert property (
        @(posedge clk) disable iff (reset_i)
        !pred_o.btb_hit |-> (!pred_o.taken && pred_o.target == fetch_pc_i + `BP_XLEN'(4)))
        else begin
            fail_count++;
            $error("a missed lookup does not predict not taken with target pc + 4");
        end

endmodule

bind bp_unit bp_unit_sva i_bp_unit_sva (
    .clk             (clk),
    .reset_i         (reset_i),
    .fetch_pc_i      (fetch_pc_i),
    .pred_o          (pred_o),
    .resolve_valid_i (resolve_valid_i),
    .redirect_o      (redirect_o)
);

//--- tb_bp_unit.sv
// Self-checking testbench for bp_unit; pcs are word aligned and the model assumes the default sizes
`timescale 1ns/100ps
`include "bp_cfg.svh"

module tb_bp_unit;

    import bp_pkg::*;

    localparam int BTB_IDX = `BP_BTB_IDX_BITS;
    localparam int BTB_N   = `BP_BTB_ENTRIES;
    localparam int GHR     = `BP_GHR_BITS;
    localparam int PHT_N   = `BP_PHT_ENTRIES;

    logic                clk;
    logic                reset_i;
    logic [`BP_XLEN-1:0] fetch_pc_i;
    bp_pred_t            pred_o;
    logic                resolve_valid_i;
    bp_resolve_t         resolve_i;
    logic                redirect_o;
    logic [`BP_XLEN-1:0] redirect_pc_o;

    // Reference model state
    logic                m_valid  [BTB_N];
    logic [`BP_XLEN-1:0] m_tag    [BTB_N];
    logic [`BP_XLEN-1:0] m_target [BTB_N];
    br_kind_e            m_kind   [BTB_N];
    logic [1:0]          m_pht    [PHT_N];
    logic [GHR-1:0]      m_ghr;
    logic                pend_redir;
    logic [`BP_XLEN-1:0] pend_pc;

    logic [15:0]         lfsr_state;
    logic [31:0]         r;
    logic [31:0]         pc_a;
    logic [31:0]         pc_b;
    logic [31:0]         pc_c;
    logic [31:0]         pc;
    logic [31:0]         tgt;
    logic [31:0]         pool [8];
    opcode_e             op;
    logic                taken;
    logic                flip;

    bp_unit i_dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .fetch_pc_i      (fetch_pc_i),
        .pred_o          (pred_o),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %0h actual %0h", test, expected, actual);
            abort_run();
        end
    endtask

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic bp_pred_t model_predict(input logic [31:0] lpc);
        bp_pred_t            p;
        logic [BTB_IDX-1:0] idx;
        idx         = lpc[BTB_IDX+1:2];
        p.pht_index = lpc[GHR+1:2] ^ m_ghr;
        p.btb_hit   = m_valid[idx] && (m_tag[idx] == lpc);
        if (p.btb_hit) begin
            p.target = m_target[idx];
            p.taken  = (m_kind[idx] == KIND_JUMP) ||
                       (m_kind[idx] == KIND_COND && m_pht[p.pht_index][1]);
        end else begin
            p.target = lpc + 32'd4;
            p.taken  = 1'b0;
        end
        return p;
    endfunction

    task automatic model_resolve(input logic [31:0] rpc, input opcode_e rop, input logic act,
                                 input logic [31:0] atgt, input bp_pred_t pr);
        br_kind_e            kind;
        logic [BTB_IDX-1:0] idx;
        case (rop)
            OP_BRANCH:      kind = KIND_COND;
            OP_JAL, OP_JALR: kind = KIND_JUMP;
            default:        kind = KIND_NONE;
        endcase
        if (kind == KIND_NONE) begin
            pend_redir = pr.taken;
        end else begin
            pend_redir = (pr.taken != act) || (pr.taken && act && pr.target != atgt);
        end
        pend_pc = act ? atgt : rpc + 32'd4;
        idx     = rpc[BTB_IDX+1:2];
        if (kind != KIND_NONE && !pr.btb_hit) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = rpc;
            m_target[idx] = atgt;
            m_kind[idx]   = kind;
        end
        if (kind == KIND_COND) begin
            if (act && m_pht[pr.pht_index] != 2'd3) begin
                m_pht[pr.pht_index] = m_pht[pr.pht_index] + 2'd1;
            end else if (!act && m_pht[pr.pht_index] != 2'd0) begin
                m_pht[pr.pht_index] = m_pht[pr.pht_index] - 2'd1;
            end
            m_ghr = {act, m_ghr[GHR-1:1]};
        end
    endtask

    // Redirect seen one cycle after the previous drive
    task automatic check_redirect(input string test);
        check_value({test, " redirect"}, pend_redir, redirect_o);
        if (pend_redir) begin
            check_value({test, " redirect_pc"}, pend_pc, redirect_pc_o);
        end
    endtask

    task automatic drive_lookup(input string test, input logic [31:0] lpc);
        @(negedge clk);
        check_redirect(test);
        fetch_pc_i      = lpc;
        resolve_valid_i = 1'b0;
        pend_redir      = 1'b0;
        #1;
        check_value({test, " lookup"}, model_predict(lpc), pred_o);
    endtask

    // Flip inverts the carried direction to force a mispredict
    task automatic drive_resolve(input string test, input logic [31:0] rpc, input opcode_e rop,
                                 input logic act, input logic [31:0] atgt, input logic flp);
        bp_pred_t carried;
        @(negedge clk);
        check_redirect(test);
        carried       = model_predict(rpc);
        carried.taken = carried.taken ^ flp;
        fetch_pc_i              = rpc;
        resolve_valid_i         = 1'b1;
        resolve_i.pc            = rpc;
        resolve_i.opcode        = rop;
        resolve_i.actual_taken  = act;
        resolve_i.actual_target = atgt;
        resolve_i.pred          = carried;
        #1;
        check_value({test, " lookup"}, model_predict(rpc), pred_o);
        model_resolve(rpc, rop, act, atgt, carried);
    endtask

    always @(negedge clk) begin
        if (i_dut.i_bp_unit_sva.fail_count != 0) begin
            $display("A concurrent assertion bound to bp_unit failed");
            abort_run();
        end
    end

    initial begin
        for (int c = 0; c < 4000; c++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within 4000 clock cycles");
        abort_run();
    end

    initial begin
        reset_i         = 1'b1;
        fetch_pc_i      = '0;
        resolve_valid_i = 1'b0;
        resolve_i       = '0;
        lfsr_state      = 16'd60;
        pend_redir      = 1'b0;
        pend_pc         = '0;
        m_ghr           = '0;
        for (int i = 0; i < BTB_N; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < PHT_N; i++) begin
            m_pht[i] = 2'd1;
        end
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
        end
        reset_i = 1'b0;

        // Empty tables fall through
        for (int i = 0; i < 12; i++) begin
            rand_bits(30, r);
            drive_lookup("reset_miss", {r[29:0], 2'b00});
        end

        // JAL learned and then an aliasing pc misses
        rand_bits(30, r);
        pc_a = {r[29:0], 2'b00};
        pc_b = pc_a ^ 32'h0000_1000;
        pc_c = pc_a ^ 32'h0000_0004;
        rand_bits(30, r);
        tgt = {r[29:0], 2'b00};
        drive_resolve("jal_learn", pc_a, OP_JAL, 1'b1, tgt, 1'b0);
        drive_lookup("jal_hit", pc_a);
        check_value("jal_hit taken", 1, pred_o.taken);
        check_value("jal_hit target", tgt, pred_o.target);
        drive_lookup("alias_miss", pc_b);
        check_value("alias_miss hit", 0, pred_o.btb_hit);

        // Mispredicts and a correct prediction
        rand_bits(30, r);
        drive_resolve("other_flipped", {r[29:0], 2'b00}, OP_OTHER, 1'b0, 32'd0, 1'b1);
        drive_resolve("other_correct", pc_c ^ 32'h40, OP_OTHER, 1'b0, 32'd0, 1'b0);
        rand_bits(30, r);
        drive_resolve("jalr_wrong_target", pc_a, OP_JALR, 1'b1, {r[29:0], 2'b00}, 1'b0);
        drive_resolve("jal_correct", pc_a, OP_JAL, 1'b1, tgt, 1'b0);

        // Conditional branch counter up to saturation and back down
        rand_bits(30, r);
        tgt = {r[29:0], 2'b00};
        for (int i = 0; i < 8; i++) begin
            drive_resolve("cond_up", pc_c, OP_BRANCH, 1'b1, tgt, 1'b0);
            drive_lookup("cond_up", pc_c);
        end
        check_value("cond_saturated taken", 1, pred_o.taken);
        for (int i = 0; i < 8; i++) begin
            drive_resolve("cond_down", pc_c, OP_BRANCH, 1'b0, pc_c + 32'd4, 1'b0);
            drive_lookup("cond_down", pc_c);
        end

        // Replacement at an occupied index
        rand_bits(30, r);
        drive_resolve("replace", pc_b, OP_JAL, 1'b1, {r[29:0], 2'b00}, 1'b0);
        drive_lookup("replace_old", pc_a);
        check_value("replace_old hit", 0, pred_o.btb_hit);
        drive_lookup("replace_new", pc_b);
        check_value("replace_new hit", 1, pred_o.btb_hit);

        // Back-to-back strobes over a pool with aliasing pcs
        for (int i = 0; i < 4; i++) begin
            rand_bits(30, r);
            pool[i]     = {r[29:0], 2'b00};
            pool[i + 4] = pool[i] ^ 32'h0000_1000;
        end
        for (int n = 0; n < 48; n++) begin
            rand_bits(3, r);
            pc = pool[r[2:0]];
            rand_bits(2, r);
            case (r[1:0])
                2'd0:    op = OP_BRANCH;
                2'd1:    op = OP_JAL;
                2'd2:    op = OP_JALR;
                default: op = OP_OTHER;
            endcase
            rand_bits(1, r);
            taken = r[0] || op == OP_JAL || op == OP_JALR;
            rand_bits(30, r);
            tgt = (op == OP_OTHER) ? pc + 32'd4 : {r[29:0], 2'b00};
            taken = taken && op != OP_OTHER;
            rand_bits(2, r);
            flip = (r[1:0] == 2'd0);
            drive_resolve("back_to_back", pc, op, taken, tgt, flip);
        end
        drive_lookup("final", pool[0]);

        if (i_dut.i_bp_unit_sva.fail_count != 0) begin
            $display("Bound assertions reported failures");
            abort_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+.
bp_pkg.sv
bp_op_decode.sv
bp_btb.sv
bp_gshare.sv
bp_resolve.sv
bp_unit.sv
bp_unit_sva.sv
tb_bp_unit.sv

//--- Bender.yml
package:
  name: bp_unit

sources:
  - include_dirs:
      - .
    files:
      - bp_pkg.sv
      - bp_op_decode.sv
      - bp_btb.sv
      - bp_gshare.sv
      - bp_resolve.sv
      - bp_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - bp_unit_sva.sv
      - tb_bp_unit.sv
